//--- hw/isa_pkg.sv
/* Instruction set definitions for the core: word widths, major opcodes,
   function codes, ALU operations and the instruction format union */
`default_nettype none

package isa_pkg;

   localparam int XLEN   = 32; // Data and address word width
   localparam int REG_AW = 5;  // Register index width

   // Major opcodes, only the subset this core executes
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011, // Register-register ALU
      OPC_OP_IMM = 7'b0010011, // Register-immediate ALU
      OPC_LUI    = 7'b0110111, // Load upper immediate
      OPC_LOAD   = 7'b0000011, // Word load
      OPC_STORE  = 7'b0100011  // Word store
   } opcode_e;

   // funct3 codes of OP and OP_IMM
   localparam logic [2:0] F3_ADD  = 3'b000; // ADD or SUB
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [6:0] F7_ALT  = 7'b0100000; // Selects SUB and SRA

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_PASS_B // Operand b straight through, for LUI
   } alu_op_e;

   typedef struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      opcode_e           opcode;
   } r_fmt_s;

   typedef struct packed {
      logic [11:0]       imm;    // imm[11:0]
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      opcode_e           opcode;
   } i_fmt_s;

   typedef struct packed {
      logic [6:0]        imm_hi; // imm[11:5]
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [4:0]        imm_lo; // imm[4:0]
      opcode_e           opcode;
   } s_fmt_s;

   typedef struct packed {
      logic [19:0]       imm;    // imm[31:12]
      logic [REG_AW-1:0] rd;
      opcode_e           opcode;
   } u_fmt_s;

   // One instruction word, read in the format its opcode calls for
   typedef union packed {
      r_fmt_s r;
      i_fmt_s i;
      s_fmt_s s;
      u_fmt_s u;
   } inst_u;

   localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
/* Pipeline stage records: decode to execute, execute to result,
   write-back, forwarding source and main memory request */
`default_nettype none

package pipe_pkg;

   import isa_pkg::*;

   // Decode to execute
   typedef struct packed {
      alu_op_e           alu_op;
      logic              is_load;
      logic              is_store;
      logic              writes_rd;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   opa;    // rs1 value after forwarding
      logic [XLEN-1:0]   opb;    // rs2 value or immediate
      logic [XLEN-1:0]   st_dat; // rs2 value, store data
   } id_ex_s;

   // Execute to result stage
   typedef struct packed {
      logic              is_load;
      logic              is_store;
      logic              writes_rd;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   res;    // ALU result, also the memory address
      logic [XLEN-1:0]   st_dat;
   } ex_ma_s;

   // Register file write port
   typedef struct packed {
      logic              writes_rd;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   dat;
   } ma_wb_s;

   // Forwarding source offered back to decode
   typedef struct packed {
      logic              we;
      logic [REG_AW-1:0] dst;
      logic [XLEN-1:0]   dat;
   } fwd_s;

   // Main memory request, write at the edge when cs and wen are high
   typedef struct packed {
      logic            cs;
      logic            wen;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] wdata;
   } mem_req_s;

endpackage

`default_nettype wire

//--- hw/regfile.sv
/* Register file, 31 writable words plus hard-wired x0,
   two read ports with write bypass and one write port */
`timescale 1ns/1ps
`default_nettype none

module regfile import isa_pkg::*, pipe_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [REG_AW-1:0] rs1,   // Read index A
   input  logic [REG_AW-1:0] rs2,   // Read index B
   output logic [XLEN-1:0]   rd1,   // Read data A
   output logic [XLEN-1:0]   rd2,   // Read data B
   input  ma_wb_s            wr     // Write-back item
);

   logic [XLEN-1:0] regs [1:2**REG_AW-1]; // x0 has no storage
   logic            wr_en;

   // Writes to x0 are dropped, no writes while in reset
   assign wr_en = rst_n && wr.writes_rd && (wr.rd != '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[wr.rd] <= wr.dat;
      end
   end

   // Same-cycle write returns the new value
   assign rd1 = (rs1 == '0)                  ? '0     :
                (wr_en && (wr.rd == rs1))    ? wr.dat : regs[rs1];
   assign rd2 = (rs2 == '0)                  ? '0     :
                (wr_en && (wr.rd == rs2))    ? wr.dat : regs[rs2];

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
/* Fetch and decode stage: PC, IR, load-use interlock, immediates,
   operand forwarding and the decode to execute register */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; #(
   parameter int INST_ADDR_W = 10          // PC wraps at this width
)(
   input  logic            clk,
   input  logic            rst_n,
   output logic [XLEN-1:0] inst_mem_addr,  // Fetch address
   input  logic [XLEN-1:0] inst_mem_dat,   // Fetched word, same cycle
   input  fwd_s            ex_fwd,         // Execute stage result
   input  logic            ex_is_load,     // Execute item is a load
   input  fwd_s            ma_fwd,         // Result stage result
   input  ma_wb_s          ma_wb,          // Register file write port
   output id_ex_s          id_ex
);

   logic [INST_ADDR_W-1:0] pc;
   inst_u                  ir;
   opcode_e                opc;
   logic [REG_AW-1:0]      rs1;
   logic [REG_AW-1:0]      rs2;
   logic [XLEN-1:0]        rf_rd1;
   logic [XLEN-1:0]        rf_rd2;
   logic [XLEN-1:0]        op1_val;        // rs1 after forwarding
   logic [XLEN-1:0]        op2_val;        // rs2 after forwarding
   logic [XLEN-1:0]        imm_i;
   logic [XLEN-1:0]        imm_s;
   logic [XLEN-1:0]        imm_u;
   logic                   alt;            // funct7 asks for SUB or SRA
   logic                   uses_rs1;
   logic                   uses_rs2;
   logic                   hit_rs1;
   logic                   hit_rs2;
   logic                   stall;          // Load-use interlock
   id_ex_s                 id_ex_nxt;

   // Newest value wins: execute, then result stage, then register file
   function automatic logic [XLEN-1:0] fwd_pick(
      input logic [REG_AW-1:0] rs,
      input logic [XLEN-1:0]   rf_val,
      input fwd_s              src_ex,
      input fwd_s              src_ma
   );
      if (rs == '0) return '0;                            // x0 stays zero
      if (src_ex.we && (src_ex.dst == rs)) return src_ex.dat;
      if (src_ma.we && (src_ma.dst == rs)) return src_ma.dat;
      return rf_val;
   endfunction

   function automatic alu_op_e alu_sel(
      input logic [2:0] f3,
      input logic       alt_op,
      input logic       reg_op       // SUB exists only in register form
   );
      case (f3)
         F3_ADD:  return (alt_op && reg_op) ? ALU_SUB : ALU_ADD;
         F3_SLL:  return ALU_SLL;
         F3_SLT:  return ALU_SLT;
         F3_SLTU: return ALU_SLTU;
         F3_XOR:  return ALU_XOR;
         F3_SR:   return alt_op ? ALU_SRA : ALU_SRL;
         F3_OR:   return ALU_OR;
         F3_AND:  return ALU_AND;
         default: return ALU_ADD;
      endcase
   endfunction

   assign inst_mem_addr = XLEN'(pc);

   // PC and IR hold while the interlock is active
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
         ir <= NOP_INST;
      end else if (!stall) begin
         pc <= pc + INST_ADDR_W'(4); // Wraps at INST_ADDR_W
         ir <= inst_mem_dat;
      end
   end

   // Field extraction, common positions for all formats
   assign opc = ir.r.opcode;
   assign rs1 = ir.r.rs1;
   assign rs2 = ir.r.rs2;
   assign alt = (ir.r.funct7 == F7_ALT);

   assign imm_i = {{(XLEN-12){ir.i.imm[11]}}, ir.i.imm};
   assign imm_s = {{(XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
   assign imm_u = {ir.u.imm, 12'h000};

   regfile regfile_i (
      .clk   (clk),
      .rst_n (rst_n),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd1   (rf_rd1),
      .rd2   (rf_rd2),
      .wr    (ma_wb)
   );

   assign op1_val = fwd_pick(rs1, rf_rd1, ex_fwd, ma_fwd);
   assign op2_val = fwd_pick(rs2, rf_rd2, ex_fwd, ma_fwd);

   // LUI reads no register, only OP and STORE read rs2
   assign uses_rs1 = (opc != OPC_LUI);
   assign uses_rs2 = (opc == OPC_OP) || (opc == OPC_STORE);
   assign hit_rs1  = (rs1 != '0) && (rs1 == id_ex.rd);
   assign hit_rs2  = (rs2 != '0) && (rs2 == id_ex.rd);
   assign stall    = ex_is_load && id_ex.writes_rd &&
                     ((uses_rs1 && hit_rs1) || (uses_rs2 && hit_rs2));

   always_comb begin
      id_ex_nxt        = '0;         // Unknown opcodes become a bubble
      id_ex_nxt.alu_op = ALU_ADD;
      id_ex_nxt.rd     = ir.r.rd;
      id_ex_nxt.opa    = op1_val;
      id_ex_nxt.st_dat = op2_val;
      case (opc)
         OPC_OP: begin
            id_ex_nxt.alu_op    = alu_sel(ir.r.funct3, alt, 1'b1);
            id_ex_nxt.opb       = op2_val;
            id_ex_nxt.writes_rd = 1'b1;
         end
         OPC_OP_IMM: begin
            id_ex_nxt.alu_op    = alu_sel(ir.i.funct3, alt, 1'b0); // SRAI sits in funct7
            id_ex_nxt.opb       = imm_i;
            id_ex_nxt.writes_rd = 1'b1;
         end
         OPC_LUI: begin
            id_ex_nxt.alu_op    = ALU_PASS_B;
            id_ex_nxt.opb       = imm_u;
            id_ex_nxt.writes_rd = 1'b1;
         end
         OPC_LOAD: begin
            id_ex_nxt.opb       = imm_i;  // Address is rs1 + imm
            id_ex_nxt.is_load   = 1'b1;
            id_ex_nxt.writes_rd = 1'b1;
         end
         OPC_STORE: begin
            id_ex_nxt.opb       = imm_s;
            id_ex_nxt.is_store  = 1'b1;
         end
         default: ;
      endcase
      if (stall) begin                 // Inject a bubble behind the load
         id_ex_nxt.is_load   = 1'b0;
         id_ex_nxt.is_store  = 1'b0;
         id_ex_nxt.writes_rd = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_ex <= '0;  // Bubble
      end else begin
         id_ex <= id_ex_nxt;
      end
   end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
/* Execute stage: ALU, forwarding of the ALU result to decode
   and the execute to result register */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  id_ex_s id_ex,       // Item in execute this cycle
   output fwd_s   ex_fwd,      // ALU result offered to decode
   output logic   ex_is_load,  // Drives the decode interlock
   output ex_ma_s ex_ma
);

   localparam int SHW = $clog2(XLEN); // Shift amount width

   logic [XLEN-1:0] a;
   logic [XLEN-1:0] b;
   logic [SHW-1:0]  shamt;
   logic [XLEN-1:0] alu_res;

   assign a     = id_ex.opa;
   assign b     = id_ex.opb;
   assign shamt = b[SHW-1:0];  // Low 5 bits only

   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD:    alu_res = a + b;
         ALU_SUB:    alu_res = a - b;
         ALU_AND:    alu_res = a & b;
         ALU_OR:     alu_res = a | b;
         ALU_XOR:    alu_res = a ^ b;
         ALU_SLT:    alu_res = XLEN'($signed(a) < $signed(b));
         ALU_SLTU:   alu_res = XLEN'(a < b);
         ALU_SLL:    alu_res = a << shamt;
         ALU_SRL:    alu_res = a >> shamt;
         ALU_SRA:    alu_res = $unsigned($signed(a) >>> shamt); // Sign fill
         ALU_PASS_B: alu_res = b;  // LUI
         default:    alu_res = a + b;
      endcase
   end

   // A load's data only exists in the result stage
   assign ex_fwd.we   = id_ex.writes_rd && !id_ex.is_load;
   assign ex_fwd.dst  = id_ex.rd;
   assign ex_fwd.dat  = alu_res;
   assign ex_is_load  = id_ex.is_load;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_ma <= '0;  // Bubble, keeps cs low after reset
      end else begin
         ex_ma.is_load   <= id_ex.is_load;
         ex_ma.is_store  <= id_ex.is_store;
         ex_ma.writes_rd <= id_ex.writes_rd;
         ex_ma.rd        <= id_ex.rd;
         ex_ma.res       <= alu_res;
         ex_ma.st_dat    <= id_ex.st_dat;
      end
   end

endmodule

`default_nettype wire

//--- hw/result_stage.sv
/* Result stage: main memory access, load data selection,
   forwarding to decode and the write-back register */
`timescale 1ns/1ps
`default_nettype none

module result_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  ex_ma_s          ex_ma,           // Item in this stage
   output mem_req_s        main_mem_req,    // Combinational from ex_ma
   input  logic [XLEN-1:0] main_mem_rdata,  // Read data, same cycle
   output fwd_s            ma_fwd,          // Result offered to decode
   output ma_wb_s          ma_wb            // Register file write, next cycle
);

   logic [XLEN-1:0] res;

   // Word accesses only, byte offset forced to zero
   assign main_mem_req.cs    = ex_ma.is_load || ex_ma.is_store;
   assign main_mem_req.wen   = ex_ma.is_store;
   assign main_mem_req.addr  = {ex_ma.res[XLEN-1:2], 2'b00};
   assign main_mem_req.wdata = ex_ma.st_dat;

   assign res = ex_ma.is_load ? main_mem_rdata : ex_ma.res;

   assign ma_fwd.we  = ex_ma.writes_rd;
   assign ma_fwd.dst = ex_ma.rd;
   assign ma_fwd.dat = res;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ma_wb <= '0;
      end else begin
         ma_wb.writes_rd <= ex_ma.writes_rd;
         ma_wb.rd        <= ex_ma.rd;
         ma_wb.dat       <= res;     // Load data or ALU result
      end
   end

endmodule

`default_nettype wire

//--- hw/etcpu_core.sv
/* Core top level: decode, execute and result stages
   with the instruction and main memory ports */
`timescale 1ns/1ps
`default_nettype none

module etcpu_core import isa_pkg::*, pipe_pkg::*; #(
   parameter int INST_ADDR_W = 10          // Instruction byte address width
)(
   input  logic            clk,
   input  logic            rst_n,
   output logic [XLEN-1:0] inst_mem_addr,  // Instruction memory address
   input  logic [XLEN-1:0] inst_mem_dat,   // Instruction word, combinational
   output mem_req_s        main_mem_req,   // Main memory request
   input  logic [XLEN-1:0] main_mem_rdata  // Main memory read data
);

   id_ex_s id_ex;       // Decode to execute
   ex_ma_s ex_ma;       // Execute to result
   fwd_s   ex_fwd;      // Forward from execute
   fwd_s   ma_fwd;      // Forward from result stage
   ma_wb_s ma_wb;       // Write-back into the register file
   logic   ex_is_load;

   decode_stage #(
      .INST_ADDR_W (INST_ADDR_W)
   ) decode_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .inst_mem_addr (inst_mem_addr),
      .inst_mem_dat  (inst_mem_dat),
      .ex_fwd        (ex_fwd),
      .ex_is_load    (ex_is_load),
      .ma_fwd        (ma_fwd),
      .ma_wb         (ma_wb),
      .id_ex         (id_ex)
   );

   execute_stage execute_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .id_ex      (id_ex),
      .ex_fwd     (ex_fwd),
      .ex_is_load (ex_is_load),
      .ex_ma      (ex_ma)
   );

   result_stage result_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .ex_ma          (ex_ma),
      .main_mem_req   (main_mem_req),
      .main_mem_rdata (main_mem_rdata),
      .ma_fwd         (ma_fwd),
      .ma_wb          (ma_wb)
   );

endmodule

`default_nettype wire

//--- tb/core_checker.sv
/* Store checker: reference execution of the program, comparison of each
   main memory write, access count, fetch address sequence and run timeout */
`timescale 1ns/1ps
`default_nettype none

module core_checker import pipe_pkg::*; #(
   parameter int PROG_LEN  = 160,
   parameter int RAM_WORDS = 64
)(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] prog     [PROG_LEN],
   input  logic [31:0] ram_init [RAM_WORDS],
   input  logic [31:0] inst_mem_addr,
   input  mem_req_s    main_mem_req,
   output logic        done,
   output logic        timed_out,
   output int          value_errs,
   output int          proto_errs
);

   localparam int TIMEOUT = 4 * PROG_LEN + 50; // Cycles after reset
   localparam int DRAIN   = 8;                 // Quiet cycles after the last store

   logic [31:0] exp_addr [PROG_LEN];
   logic [31:0] exp_data [PROG_LEN];
   int          exp_cnt;      // Stores in the program
   int          exp_mem_ops;  // Loads plus stores
   int          exp_holds;    // Load-use pairs, one bubble each
   int          seen;
   int          cs_cycles;
   int          cycles;
   int          drain_cnt;
   int          rst_cycles;
   int          holds;        // Cycles the fetch address held
   logic [31:0] exp_pc;       // Next fetch address in order
   logic        pc_held;      // Fetch held in the cycle before
   logic        ref_done;

   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      logic signed [31:0] sa;
      logic signed [31:0] sb;
      sa = a;
      sb = b;
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return (sa < sb) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5: begin
            if (alt) return sa >>> b[4:0];  // Sign fill
            return a >> b[4:0];
         end
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   // Runs the program in order and lists every store it makes
   function automatic void run_reference();
      logic [31:0] x   [32];
      logic [31:0] ram [RAM_WORDS];
      logic [31:0] ins;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] addr;
      logic [31:0] res;
      logic        wr;
      logic [4:0]  ld_rd;  // rd of a load just before, 0 if none
      exp_cnt     = 0;
      exp_mem_ops = 0;
      exp_holds   = 0;
      ld_rd       = '0;
      for (int i = 0; i < 32; i++) begin
         x[i] = '0;
      end
      for (int i = 0; i < RAM_WORDS; i++) begin
         ram[i] = ram_init[i];
      end
      for (int pc = 0; pc < PROG_LEN; pc++) begin
         ins   = prog[pc];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         wr    = 1'b1;
         res   = '0;
         // Load result read at once, rs2 counts only for OP and STORE
         if (ld_rd != 5'd0 && ins[6:0] != 7'b0110111 &&
             (ins[19:15] == ld_rd ||
              ((ins[6:0] == 7'b0110011 || ins[6:0] == 7'b0100011) &&
               ins[24:20] == ld_rd))) begin
            exp_holds++;
         end
         ld_rd = (ins[6:0] == 7'b0000011) ? ins[11:7] : 5'd0;
         case (ins[6:0])
            7'b0110011: res = alu_ref(ins[14:12], ins[31:25] == 7'h20,
                                      x[ins[19:15]], x[ins[24:20]]);
            7'b0010011: res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[31:25] == 7'h20,
                                      x[ins[19:15]], imm_i);   // No SUBI
            7'b0110111: res = {ins[31:12], 12'h000};
            7'b0000011: begin
               addr = x[ins[19:15]] + imm_i;
               res  = ram[addr[7:2]];
               exp_mem_ops++;
            end
            7'b0100011: begin
               addr              = x[ins[19:15]] + imm_s;
               ram[addr[7:2]]    = x[ins[24:20]];
               exp_addr[exp_cnt] = addr;
               exp_data[exp_cnt] = x[ins[24:20]];
               exp_cnt++;
               exp_mem_ops++;
               wr = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;  // x0 stays zero
      end
   endfunction

   task automatic check_write();
      if (seen >= exp_cnt) begin
         proto_errs++;
         $display("write strobe with no store left to match it, addr %h", main_mem_req.addr);
      end else begin
         if (main_mem_req.addr !== exp_addr[seen]) begin
            value_errs++;
            $display("error: main_mem_req.addr store %0d got %h expected %h",
                     seen, main_mem_req.addr, exp_addr[seen]);
         end
         if (main_mem_req.wdata !== exp_data[seen]) begin
            value_errs++;
            $display("error: main_mem_req.wdata store %0d got %h expected %h",
                     seen, main_mem_req.wdata, exp_data[seen]);
         end
         seen++;
      end
   endtask

   // Fetch steps one word per cycle, or holds one cycle behind a load
   task automatic check_fetch();
      if (inst_mem_addr === exp_pc) begin
         exp_pc  = exp_pc + 32'd4;
         pc_held = 1'b0;
      end else if (inst_mem_addr === exp_pc - 32'd4 && !pc_held) begin
         holds++;
         pc_held = 1'b1;
      end else begin
         value_errs++;
         $display("error: inst_mem_addr cycle %0d got %h expected %h",
                  cycles, inst_mem_addr, exp_pc);
         exp_pc = exp_pc + 32'd4;
      end
   endtask

   initial begin
      done       = 1'b0;
      timed_out  = 1'b0;
      value_errs = 0;
      proto_errs = 0;
      seen       = 0;
      cs_cycles  = 0;
      cycles     = 0;
      drain_cnt  = 0;
      rst_cycles = 0;
      holds      = 0;
      exp_pc     = '0;
      pc_held    = 1'b0;
      ref_done   = 1'b0;
   end

   // Sampled at the edge, where the RAM model also writes
   always @(posedge clk) begin
      if (!rst_n) begin
         // Bubbles in every stage from the first reset edge on
         if (rst_cycles > 0 &&
             (main_mem_req.cs !== 1'b0 || main_mem_req.wen !== 1'b0)) begin
            proto_errs++;
            $display("main memory selected during reset");
         end
         rst_cycles++;
      end else if (!done) begin
         if (!ref_done) begin
            run_reference();
            ref_done = 1'b1;
         end
         cycles++;
         check_fetch();
         if (main_mem_req.cs === 1'b1) cs_cycles++;
         if (main_mem_req.cs === 1'b1 && main_mem_req.wen === 1'b1) check_write();
         if (seen == exp_cnt) begin                 // Watch for late strobes a while
            drain_cnt++;
            if (drain_cnt == DRAIN) begin
               if (cs_cycles != exp_mem_ops) begin
                  proto_errs++;
                  $display("main memory selected in %0d cycles, program has %0d accesses",
                           cs_cycles, exp_mem_ops);
               end
               if (holds != exp_holds) begin
                  proto_errs++;
                  $display("fetch held in %0d cycles, program has %0d load-use pairs",
                           holds, exp_holds);
               end
               done = 1'b1;
            end
         end else if (cycles >= TIMEOUT) begin
            $display("timeout: not all stores seen");
            timed_out = 1'b1;
            done      = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb/core_tb.sv
/* Testbench top: clock, reset, random program generation, instruction ROM
   and data RAM models around the core, with the store checker */
`timescale 1ns/1ps
`default_nettype none

module core_tb import pipe_pkg::*; ();

   localparam int          PROG_LEN  = 160;          // Fits well inside the 256-word PC range
   localparam int          RAM_WORDS = 64;
   localparam logic [31:0] NOP_WORD  = 32'h0000_0013; // addi x0, x0, 0
   localparam logic [6:0]  IMM_OPC   = 7'b0010011;
   localparam logic [6:0]  LD_OPC    = 7'b0000011;
   // funct3 per selector, entry 0 in the low bits
   localparam logic [29:0] OP_F3  = {3'd5, 3'd5, 3'd1, 3'd3, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
   localparam logic [26:0] IMM_F3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};

   logic        clk;
   logic        rst_n;
   logic [31:0] inst_mem_addr;
   logic [31:0] inst_mem_dat;
   mem_req_s    main_mem_req;
   logic [31:0] main_mem_rdata;
   logic [31:0] prog     [PROG_LEN];
   logic [31:0] ram_init [RAM_WORDS]; // Preset image, kept for the reference
   logic [31:0] ram      [RAM_WORDS];
   int          n;                    // Next free program slot
   int          op_cnt;               // Rotates through all ten register ops
   int          imm_cnt;              // Rotates through all nine immediate ops
   logic        done;
   logic        timed_out;
   int          value_errs;
   int          proto_errs;

   // ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
   function automatic logic [31:0] op_word(input int sel, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
      return {(sel == 1 || sel == 9) ? 7'h20 : 7'h00, rs2, rs1, OP_F3[sel*3 +: 3], rd,
              7'b0110011};
   endfunction

   function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
   endfunction

   function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'($urandom_range(0, 7)); // x0 to x7 only, x31 stays the base
   endfunction

   // Word offset 0 to 15 from base 32, so both signs of the immediate occur
   function automatic logic [11:0] ram_offset();
      return 12'(($urandom_range(0, 15) << 2) - 32);
   endfunction

   task automatic put_inst(input logic [31:0] w);
      prog[n] = w;
      n = n + 1;
   endtask

   task automatic gen_program();
      int          kind;
      int          sel;
      logic [4:0]  rd;
      logic [11:0] imm;
      n = 0;
      put_inst(imm_word(12'd32, 5'd0, 3'd0, 5'd31, IMM_OPC)); // Base register x31
      for (int r = 1; r < 8; r++) begin                       // Random 32-bit start values
         put_inst(lui_word(20'($urandom), 5'(r)));
         put_inst(imm_word(12'($urandom), 5'(r), 3'd0, 5'(r), IMM_OPC));
      end
      while (n < PROG_LEN - 8) begin
         kind = $urandom_range(0, 9);
         rd   = rand_reg();
         if (kind == 7 && n >= PROG_LEN - 9) kind = 8;   // No room left for a pair
         case (kind)
            0, 1, 2, 3: begin
               put_inst(op_word(op_cnt % 10, rd, rand_reg(), rand_reg()));
               op_cnt++;
            end
            4, 5: begin
               sel = imm_cnt % 9;
               imm = (sel >= 6) ? {(sel == 8) ? 7'h20 : 7'h00, 5'($urandom)} : 12'($urandom);
               put_inst(imm_word(imm, rand_reg(), IMM_F3[sel*3 +: 3], rd, IMM_OPC));
               imm_cnt++;
            end
            6: put_inst(lui_word(20'($urandom), rd));
            7: begin
               put_inst(imm_word(ram_offset(), 5'd31, 3'b010, rd, LD_OPC));
               if ($urandom_range(0, 1) == 1) begin
                  put_inst(store_word(ram_offset(), rd, 5'd31)); // Load result stored at once
               end else begin
                  put_inst(op_word(op_cnt % 10, rand_reg(), rd, rand_reg())); // Used as rs1
                  op_cnt++;
               end
            end
            default: put_inst(store_word(ram_offset(), rand_reg(), 5'd31));
         endcase
      end
      for (int r = 0; r < 8; r++) begin // Final dump of x0 to x7
         put_inst(store_word(12'(4 * r - 32), 5'(r), 5'd31));
      end
   endtask

   function automatic logic [31:0] rom_word(input logic [31:0] a);
      if ($isunknown(a) || a[31:2] >= PROG_LEN) return NOP_WORD; // NOPs past the program
      return prog[a[31:2]];
   endfunction

   function automatic logic [31:0] ram_word(input logic [31:0] a);
      if ($isunknown(a)) return '0;
      return ram[a[7:2]];
   endfunction

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   // Memory answers, driven 2 ns after the edge from the settled address
   always @(posedge clk) begin
      #2;
      inst_mem_dat   = rom_word(inst_mem_addr);
      main_mem_rdata = ram_word(main_mem_req.addr);
   end

   always @(posedge clk) begin
      if (main_mem_req.cs === 1'b1 && main_mem_req.wen === 1'b1) begin
         ram[main_mem_req.addr[7:2]] <= main_mem_req.wdata;
      end
   end

   initial begin
      void'($urandom(58));  // One seed for the whole run
      rst_n          = 1'b0;
      inst_mem_dat   = NOP_WORD;
      main_mem_rdata = '0;
      op_cnt         = 0;
      imm_cnt        = 0;
      for (int i = 0; i < RAM_WORDS; i++) begin
         ram_init[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h6A09_E667; // Pattern of the full index
         ram[i]      = ram_init[i];
      end
      gen_program();
      repeat (10) @(posedge clk);
      #2 rst_n = 1'b1;
      wait (done);
      $display("value errors %0d, protocol errors %0d, timeouts %0d",
               value_errs, proto_errs, timed_out ? 1 : 0);
      if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   etcpu_core #(
      .INST_ADDR_W (10)
   ) dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .inst_mem_addr  (inst_mem_addr),
      .inst_mem_dat   (inst_mem_dat),
      .main_mem_req   (main_mem_req),
      .main_mem_rdata (main_mem_rdata)
   );

   core_checker #(
      .PROG_LEN  (PROG_LEN),
      .RAM_WORDS (RAM_WORDS)
   ) chk_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .prog          (prog),
      .ram_init      (ram_init),
      .inst_mem_addr (inst_mem_addr),
      .main_mem_req  (main_mem_req),
      .done          (done),
      .timed_out     (timed_out),
      .value_errs    (value_errs),
      .proto_errs    (proto_errs)
   );

endmodule

`default_nettype wire

//--- sim.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/etcpu_core.sv
tb/core_checker.sv
tb/core_tb.sv
